/* bench/dispatch_tests.svh */
// Directed dispatch tests

// drives one warp on a slot and queues the packets it must turn into
task automatic issue_warp(input int s, input logic [`DSP_UUID_W-1:0] uuid,
                          input logic [`DSP_WIS_W-1:0] wis, input logic [`DSP_OP_W-1:0] op,
                          input logic [`DSP_THREADS-1:0] tmask);
    pkt_t pkt;
    int   first;
    int   last;
    slot_uuid[s]  = uuid;
    slot_wis[s]   = wis;
    slot_op[s]    = op;
    slot_tmask[s] = tmask;
    for (int t = 0; t < `DSP_THREADS; t++) begin
        slot_rs1[s][t] = `DSP_XLEN'(take_bits(`DSP_XLEN));
        slot_rs2[s][t] = `DSP_XLEN'(take_bits(`DSP_XLEN));
    end
    // an all-inactive warp still goes out once, as packet 0
    first = 0;
    last  = 0;
    for (int k = NUM_PACKETS - 1; k >= 0; k--) begin
        if (|tmask[k*`DSP_LANES +: `DSP_LANES]) begin
            first = k;
            last  = (last == 0 && k > last) ? k : last;
        end
    end
    for (int k = 0; k < NUM_PACKETS; k++) begin
        if ((|tmask[k*`DSP_LANES +: `DSP_LANES]) || (k == 0 && tmask == '0)) begin
            pkt.uuid  = uuid;
            pkt.wid   = {wis, SLOT_W'(s)};
            pkt.op    = op;
            pkt.tmask = tmask[k*`DSP_LANES +: `DSP_LANES];
            for (int j = 0; j < `DSP_LANES; j++) begin
                pkt.rs1[j] = slot_rs1[s][k*`DSP_LANES + j];
                pkt.rs2[j] = slot_rs2[s][k*`DSP_LANES + j];
            end
            pkt.pid = PID_W'(k);
            pkt.sop = (k == first);
            pkt.eop = (k == last);
            exp_q[s].push_back(pkt);
        end
    end
    issued[s]++;
    slot_valid[s] = 1'b1;
    @(posedge clk);
    while (!slot_ready[s]) @(posedge clk);
    @(negedge clk);
    slot_valid[s] = 1'b0;
endtask

// waits for every queued packet, then matches them per slot
task automatic check_output(input bit alternate);
    pkt_t got;
    pkt_t prev;
    int   n;
    int   s;
    int   last_slot;
    n = 0;
    for (int i = 0; i < `DSP_ISSUE_WIDTH; i++) n += exp_q[i].size();
    while (got_q.size() < n) @(posedge clk);
    repeat (8) @(posedge clk);
    check_count("packets out", got_q.size(), n);
    last_slot = -1;
    prev      = '0;
    prev.eop  = 1'b1;
    while (got_q.size() > 0) begin
        got = got_q.pop_front();
        s   = int'(got.wid[SLOT_W-1:0]);
        if (!prev.eop && got.uuid != prev.uuid) begin
            report_problem("a packet of another warp arrived inside an open warp");
        end
        if (alternate && got.sop && s == last_slot) begin
            report_problem($sformatf("two warps in a row came from slot %0d", s));
        end
        if (got.sop) last_slot = s;
        if (exp_q[s].size() == 0) begin
            report_problem($sformatf("slot %0d sent a packet nobody expected", s));
        end else begin
            check_packet("packet", got, exp_q[s].pop_front());
        end
        prev = got;
    end
    for (int i = 0; i < `DSP_ISSUE_WIDTH; i++) begin
        exp_q[i].delete();
        check_slot_release(i);
    end
endtask

task automatic verify_reset_state();
    if (exe_valid !== 1'b0) report_mismatch("exe_valid is not low after reset");
    if (slot_ready !== '0) report_mismatch($sformatf("slot_ready is %b after reset", slot_ready));
endtask

task automatic send_full_warp();
    @(negedge clk);
    issue_warp(0, 8'h11, 2'd2, 4'h3, 8'hFF);
    check_output(1'b0);
endtask

task automatic send_partial_masks();
    @(negedge clk);
    issue_warp(0, 8'h21, 2'd1, 4'h5, 8'hF0);
    issue_warp(0, 8'h22, 2'd3, 4'h5, 8'h0F);
    issue_warp(0, 8'h23, 2'd0, 4'h7, 8'h00);
    issue_warp(1, 8'h24, 2'd2, 4'h9, 8'h00);
    issue_warp(1, 8'h25, 2'd1, 4'h9, 8'h81);
    check_output(1'b0);
endtask

task automatic interleave_both_slots();
    @(negedge clk);
    fork
        for (int i = 0; i < 3; i++) begin
            issue_warp(0, `DSP_UUID_W'(8'h40 + i), `DSP_WIS_W'(i), 4'h6, 8'hFF);
        end
        for (int i = 0; i < 3; i++) begin
            issue_warp(1, `DSP_UUID_W'(8'h50 + i), `DSP_WIS_W'(i + 1), 4'hA, 8'h3C);
        end
    join
    check_output(1'b1);
endtask

// random warps on both slots while the execute port stalls at random
task automatic stall_random_warps();
    stall_en = 1'b1;
    @(negedge clk);
    fork
        for (int i = 0; i < RAND_WARPS / 2; i++) begin
            issue_warp(0, `DSP_UUID_W'(8'h80 + i), `DSP_WIS_W'(i),
                       `DSP_OP_W'(take_bits(`DSP_OP_W)), `DSP_THREADS'(take_bits(`DSP_THREADS)));
        end
        for (int i = 0; i < RAND_WARPS / 2; i++) begin
            issue_warp(1, `DSP_UUID_W'(8'hC0 + i), `DSP_WIS_W'(i),
                       `DSP_OP_W'(take_bits(`DSP_OP_W)), `DSP_THREADS'(take_bits(`DSP_THREADS)));
        end
    join
    check_output(1'b0);
    stall_en = 1'b0;
endtask

/* bench/lane_dispatch_tb.sv */
// Lane dispatch testbench

`timescale 1ns/1ps

`include "dispatch_defines.svh"

module lane_dispatch_tb import dispatch_pkg::*; ();

    localparam int TEST_TASKS      = 5;
    localparam int RAND_WARPS      = 24;
    localparam int WATCHDOG_CYCLES = TEST_TASKS * 200 + RAND_WARPS * 50;

    typedef struct packed {
        logic [`DSP_UUID_W-1:0]               uuid;
        logic [NW_W-1:0]                      wid;
        logic [`DSP_OP_W-1:0]                 op;
        logic [`DSP_LANES-1:0]                tmask;
        logic [`DSP_LANES-1:0][`DSP_XLEN-1:0] rs1;
        logic [`DSP_LANES-1:0][`DSP_XLEN-1:0] rs2;
        logic [PID_W-1:0]                     pid;
        logic                                 sop;
        logic                                 eop;
    } pkt_t;

    logic clk = 1'b0;
    logic reset;
    logic [`DSP_ISSUE_WIDTH-1:0]                                   slot_valid;
    logic [`DSP_ISSUE_WIDTH-1:0]                                   slot_ready;
    logic [`DSP_ISSUE_WIDTH-1:0][`DSP_UUID_W-1:0]                  slot_uuid;
    logic [`DSP_ISSUE_WIDTH-1:0][`DSP_WIS_W-1:0]                   slot_wis;
    logic [`DSP_ISSUE_WIDTH-1:0][`DSP_OP_W-1:0]                    slot_op;
    logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0]                 slot_tmask;
    logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0][`DSP_XLEN-1:0]  slot_rs1;
    logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0][`DSP_XLEN-1:0]  slot_rs2;
    logic                                 exe_valid;
    logic                                 exe_ready = 1'b1;
    logic [`DSP_UUID_W-1:0]               exe_uuid;
    logic [NW_W-1:0]                      exe_wid;
    logic [`DSP_OP_W-1:0]                 exe_op;
    logic [`DSP_LANES-1:0]                exe_tmask;
    logic [`DSP_LANES-1:0][`DSP_XLEN-1:0] exe_rs1;
    logic [`DSP_LANES-1:0][`DSP_XLEN-1:0] exe_rs2;
    logic [PID_W-1:0]                     exe_pid;
    logic                                 exe_sop;
    logic                                 exe_eop;

    logic        stall_en = 1'b0;
    logic [15:0] lfsr = 16'd42;
    pkt_t        got_q[$];
    pkt_t        exp_q[`DSP_ISSUE_WIDTH][$];
    pkt_t        held_pkt;
    logic        held = 1'b0;
    int          issued[`DSP_ISSUE_WIDTH];
    int          released[`DSP_ISSUE_WIDTH];
    int          eop_seen[`DSP_ISSUE_WIDTH];
    int          pending[`DSP_ISSUE_WIDTH];
    int          value_errors = 0;
    int          other_errors = 0;

    lane_dispatch u_dut (.*);

    always #10 clk = ~clk;

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_packet(input string what, input pkt_t got, input pkt_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s uuid %h pid %h sop %b eop %b, expected %h %h %b %b",
                what, got.uuid, got.pid, got.sop, got.eop, exp.uuid, exp.pid, exp.sop,
                exp.eop));
            $display("  got  %h", got);
            $display("  want %h", exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_slot_release(input int s);
        check_count($sformatf("slot %0d releases", s), released[s], issued[s]);
        check_count($sformatf("slot %0d eop packets", s), eop_seen[s], released[s]);
        if (pending[s] != 0) begin
            report_problem($sformatf("slot %0d was released without its eop packet", s));
        end
    endtask

    `include "dispatch_tests.svh"

    // output monitor with the stall and release bookkeeping
    always @(posedge clk) begin
        pkt_t cur;
        int   s;
        cur = '{uuid: exe_uuid, wid: exe_wid, op: exe_op, tmask: exe_tmask,
                rs1: exe_rs1, rs2: exe_rs2, pid: exe_pid, sop: exe_sop, eop: exe_eop};
        if (reset) begin
            held = 1'b0;
        end else begin
            if (held && !exe_valid) begin
                report_problem("exe_valid dropped before the stalled packet was taken");
            end else if (held) begin
                check_packet("stalled output", cur, held_pkt);
            end
            held     = exe_valid && !exe_ready;
            held_pkt = cur;
            if (exe_valid && exe_ready) begin
                got_q.push_back(cur);
                s = int'(cur.wid[SLOT_W-1:0]);
                if (cur.eop) begin
                    eop_seen[s]++;
                    if (pending[s] == 0) begin
                        report_problem("an eop packet left before its slot was released");
                    end else begin
                        pending[s]--;
                    end
                end
            end
            for (int i = 0; i < `DSP_ISSUE_WIDTH; i++) begin
                if (slot_ready[i]) begin
                    if (!slot_valid[i]) begin
                        report_problem($sformatf("slot %0d released while not valid", i));
                    end
                    released[i]++;
                    pending[i]++;
                end
            end
        end
    end

    always @(negedge clk) begin
        exe_ready = stall_en ? (take_bits(1) != 0) : 1'b1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        slot_valid = '0;
        slot_uuid  = '0;
        slot_wis   = '0;
        slot_op    = '0;
        slot_tmask = '0;
        slot_rs1   = '0;
        slot_rs2   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        verify_reset_state();
        send_full_warp();
        send_partial_masks();
        interleave_both_slots();
        stall_random_warps();
        $display("errors: %0d value mismatches, %0d protocol problems",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* lane_dispatch.f */
+incdir+rtl
+incdir+bench
rtl/dispatch_pkg.sv
rtl/slot_rotator.sv
rtl/packet_select.sv
rtl/packet_sequencer.sv
rtl/exec_skid_buffer.sv
rtl/lane_dispatch.sv
bench/lane_dispatch_tb.sv

/* rtl/dispatch_defines.svh */
// Dispatch stage sizes

`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// issue slots feeding the stage
`define DSP_ISSUE_WIDTH 2

// threads per warp and lanes of the execute port
`define DSP_THREADS 8
`define DSP_LANES 4

// operand width
`define DSP_XLEN 16

// instruction fields
`define DSP_UUID_W 8
`define DSP_OP_W 4
`define DSP_WIS_W 2

`endif

/* rtl/dispatch_pkg.sv */
// Dispatch stage package

`include "dispatch_defines.svh"

package dispatch_pkg;

    // each warp is cut into this many lane packets
    localparam int NUM_PACKETS = `DSP_THREADS / `DSP_LANES;

    localparam int PID_W = (NUM_PACKETS > 1) ? $clog2(NUM_PACKETS) : 1;

    localparam int SLOT_W = (`DSP_ISSUE_WIDTH > 1) ? $clog2(`DSP_ISSUE_WIDTH) : 1;

    // warp id holds the warp-in-slot number above the slot index
    localparam int NW_W = `DSP_WIS_W + SLOT_W;

    function automatic logic [NW_W-1:0] warp_id_of(
        input logic [`DSP_WIS_W-1:0] wis,
        input logic [SLOT_W-1:0]     slot
    );
        logic [NW_W-1:0] wid;
        wid = {wis, slot};
        return wid;
    endfunction

endpackage

/* rtl/exec_skid_buffer.sv */
// Execute port elastic buffer

`timescale 1ns/1ps

module exec_skid_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [DATAW-1:0] in_data,
    output logic             in_ready,
    output logic             out_valid,
    output logic [DATAW-1:0] out_data,
    input  logic             out_ready
);

    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             out_free;
    logic             in_fire;

    // the skid entry catches one packet while the output is stalled
    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    assign out_free = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_valid) begin
                out_data <= in_data;
            end
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

    out_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

/* rtl/lane_dispatch.sv */
// Lane dispatch stage

`timescale 1ns/1ps

`include "dispatch_defines.svh"

module lane_dispatch import dispatch_pkg::*; (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [`DSP_ISSUE_WIDTH-1:0]                           slot_valid,
    output logic [`DSP_ISSUE_WIDTH-1:0]                           slot_ready,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_UUID_W-1:0]          slot_uuid,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_WIS_W-1:0]           slot_wis,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_OP_W-1:0]            slot_op,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0]         slot_tmask,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0][`DSP_XLEN-1:0] slot_rs1,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0][`DSP_XLEN-1:0] slot_rs2,
    output logic                                                  exe_valid,
    input  logic                                                  exe_ready,
    output logic [`DSP_UUID_W-1:0]                                exe_uuid,
    output logic [NW_W-1:0]                                       exe_wid,
    output logic [`DSP_OP_W-1:0]                                  exe_op,
    output logic [`DSP_LANES-1:0]                                 exe_tmask,
    output logic [`DSP_LANES-1:0][`DSP_XLEN-1:0]                  exe_rs1,
    output logic [`DSP_LANES-1:0][`DSP_XLEN-1:0]                  exe_rs2,
    output logic [PID_W-1:0]                                      exe_pid,
    output logic                                                  exe_sop,
    output logic                                                  exe_eop
);

    localparam int PKT_W = `DSP_UUID_W + NW_W + `DSP_OP_W + `DSP_LANES
                         + 2 * `DSP_LANES * `DSP_XLEN + PID_W + 2;

    logic [SLOT_W-1:0]                      cur_slot;
    logic                                   cur_valid;
    logic [`DSP_UUID_W-1:0]                 cur_uuid;
    logic [NW_W-1:0]                        cur_wid;
    logic [`DSP_OP_W-1:0]                   cur_op;
    logic [`DSP_THREADS-1:0]                cur_tmask;
    logic [`DSP_THREADS-1:0][`DSP_XLEN-1:0] cur_rs1;
    logic [`DSP_THREADS-1:0][`DSP_XLEN-1:0] cur_rs2;
    logic [PID_W-1:0]                       start_pid;
    logic [PID_W-1:0]                       end_pid;
    logic [`DSP_LANES-1:0]                  pkt_tmask;
    logic [`DSP_LANES-1:0][`DSP_XLEN-1:0]   pkt_rs1;
    logic [`DSP_LANES-1:0][`DSP_XLEN-1:0]   pkt_rs2;
    logic                                   pkt_valid;
    logic                                   pkt_ready;
    logic                                   pkt_sop;
    logic                                   pkt_eop;
    logic [NUM_PACKETS-1:0]                 sent_mask;
    logic                                   batch_done;
    logic [PKT_W-1:0]                       in_word;
    logic [PKT_W-1:0]                       out_word;

    slot_rotator u_rotator (
        .clk, .reset, .batch_done, .slot_valid, .slot_uuid, .slot_wis, .slot_op,
        .slot_tmask, .slot_rs1, .slot_rs2, .cur_slot, .cur_valid, .cur_uuid,
        .cur_wid, .cur_op, .cur_tmask, .cur_rs1, .cur_rs2
    );

    packet_select u_select (
        .cur_tmask, .cur_rs1, .cur_rs2, .sent_mask,
        .start_pid, .end_pid, .pkt_tmask, .pkt_rs1, .pkt_rs2
    );

    packet_sequencer u_sequencer (
        .clk, .reset, .cur_valid, .cur_slot, .start_pid, .end_pid, .pkt_ready,
        .pkt_valid, .pkt_sop, .pkt_eop, .sent_mask, .batch_done, .slot_ready
    );

    // field order of the buffer word matches the unpacking below
    assign in_word = {cur_uuid, cur_wid, cur_op, pkt_tmask, pkt_rs1, pkt_rs2,
                      start_pid, pkt_sop, pkt_eop};

    exec_skid_buffer #(.DATAW(PKT_W)) u_buffer (
        .clk, .reset, .in_valid(pkt_valid), .in_data(in_word), .in_ready(pkt_ready),
        .out_valid(exe_valid), .out_data(out_word), .out_ready(exe_ready)
    );

    assign {exe_uuid, exe_wid, exe_op, exe_tmask, exe_rs1, exe_rs2,
            exe_pid, exe_sop, exe_eop} = out_word;

endmodule

/* rtl/packet_select.sv */
// Lane packet selection

`timescale 1ns/1ps

`include "dispatch_defines.svh"

module packet_select import dispatch_pkg::*; (
    input  logic [`DSP_THREADS-1:0]                cur_tmask,
    input  logic [`DSP_THREADS-1:0][`DSP_XLEN-1:0] cur_rs1,
    input  logic [`DSP_THREADS-1:0][`DSP_XLEN-1:0] cur_rs2,
    input  logic [NUM_PACKETS-1:0]                 sent_mask,
    output logic [PID_W-1:0]                       start_pid,
    output logic [PID_W-1:0]                       end_pid,
    output logic [`DSP_LANES-1:0]                  pkt_tmask,
    output logic [`DSP_LANES-1:0][`DSP_XLEN-1:0]   pkt_rs1,
    output logic [`DSP_LANES-1:0][`DSP_XLEN-1:0]   pkt_rs2
);

    logic [NUM_PACKETS-1:0][`DSP_LANES-1:0]                per_tmask;
    logic [NUM_PACKETS-1:0][`DSP_LANES-1:0][`DSP_XLEN-1:0] per_rs1;
    logic [NUM_PACKETS-1:0][`DSP_LANES-1:0][`DSP_XLEN-1:0] per_rs2;
    logic [NUM_PACKETS-1:0]                                nonempty;

    // packet i takes threads i*LANES up to i*LANES+LANES-1
    for (genvar i = 0; i < NUM_PACKETS; i++) begin : g_pkt
        for (genvar j = 0; j < `DSP_LANES; j++) begin : g_lane
            localparam int K = i * `DSP_LANES + j;
            assign per_tmask[i][j] = cur_tmask[K];
            assign per_rs1[i][j]   = cur_rs1[K];
            assign per_rs2[i][j]   = cur_rs2[K];
        end
        assign nonempty[i] = |per_tmask[i];
    end

    // lowest nonempty packet that has not gone out yet
    always_comb begin
        logic found;
        found     = 1'b0;
        start_pid = '0;
        for (int i = 0; i < NUM_PACKETS; i++) begin
            if (nonempty[i] && !sent_mask[i] && !found) begin
                start_pid = PID_W'(i);
                found     = 1'b1;
            end
        end
    end

    // highest nonempty packet, the last one wins the scan
    always_comb begin
        end_pid = '0;
        for (int i = 0; i < NUM_PACKETS; i++) begin
            if (nonempty[i]) begin
                end_pid = PID_W'(i);
            end
        end
    end

    // an all-zero warp falls back to packet 0 with an empty mask
    assign pkt_tmask = per_tmask[start_pid];
    assign pkt_rs1   = per_rs1[start_pid];
    assign pkt_rs2   = per_rs2[start_pid];

endmodule

/* rtl/packet_sequencer.sv */
// Lane packet sequencer

`timescale 1ns/1ps

`include "dispatch_defines.svh"

module packet_sequencer import dispatch_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cur_valid,
    input  logic [SLOT_W-1:0]           cur_slot,
    input  logic [PID_W-1:0]            start_pid,
    input  logic [PID_W-1:0]            end_pid,
    input  logic                        pkt_ready,
    output logic                        pkt_valid,
    output logic                        pkt_sop,
    output logic                        pkt_eop,
    output logic [NUM_PACKETS-1:0]      sent_mask,
    output logic                        batch_done,
    output logic [`DSP_ISSUE_WIDTH-1:0] slot_ready
);

    localparam logic IDLE_SLOT = 1'b0;
    localparam logic SENDING   = 1'b1;

    logic state;
    logic fire;
    logic fire_eop;

    assign pkt_valid = cur_valid;
    assign pkt_sop   = (state == IDLE_SLOT);
    assign pkt_eop   = (start_pid == end_pid);

    assign fire      = pkt_valid && pkt_ready;
    assign fire_eop  = fire && pkt_eop;

    assign batch_done = !cur_valid || fire_eop;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE_SLOT;
            sent_mask <= '0;
        end else if (batch_done) begin
            state     <= IDLE_SLOT;
            sent_mask <= '0;
        end else if (fire) begin
            state              <= SENDING;
            sent_mask[start_pid] <= 1'b1;
        end
    end

    // only the slot being served is released, and only with its last packet
    always_comb begin
        slot_ready = '0;
        if (fire_eop) begin
            slot_ready[cur_slot] = 1'b1;
        end
    end

    slot_ready_onehot_a: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(slot_ready)
    );

    // a slot may not vanish halfway through its packets
    no_valid_when_idle_a: assert property (
        @(posedge clk) disable iff (reset)
        !cur_valid |-> state == IDLE_SLOT
    );

endmodule

/* rtl/slot_rotator.sv */
// Issue slot rotator

`timescale 1ns/1ps

`include "dispatch_defines.svh"

module slot_rotator import dispatch_pkg::*; (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  batch_done,
    input  logic [`DSP_ISSUE_WIDTH-1:0]                           slot_valid,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_UUID_W-1:0]          slot_uuid,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_WIS_W-1:0]           slot_wis,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_OP_W-1:0]            slot_op,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0]         slot_tmask,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0][`DSP_XLEN-1:0] slot_rs1,
    input  logic [`DSP_ISSUE_WIDTH-1:0][`DSP_THREADS-1:0][`DSP_XLEN-1:0] slot_rs2,
    output logic [SLOT_W-1:0]                                     cur_slot,
    output logic                                                  cur_valid,
    output logic [`DSP_UUID_W-1:0]                                cur_uuid,
    output logic [NW_W-1:0]                                       cur_wid,
    output logic [`DSP_OP_W-1:0]                                  cur_op,
    output logic [`DSP_THREADS-1:0]                               cur_tmask,
    output logic [`DSP_THREADS-1:0][`DSP_XLEN-1:0]                cur_rs1,
    output logic [`DSP_THREADS-1:0][`DSP_XLEN-1:0]                cur_rs2
);

    // the counter moves on once the current slot is finished or empty
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_slot <= '0;
        end else if (batch_done) begin
            if (cur_slot == SLOT_W'(`DSP_ISSUE_WIDTH - 1)) begin
                cur_slot <= '0;
            end else begin
                cur_slot <= cur_slot + SLOT_W'(1);
            end
        end
    end

    assign cur_valid = slot_valid[cur_slot];
    assign cur_uuid  = slot_uuid[cur_slot];
    assign cur_op    = slot_op[cur_slot];
    assign cur_tmask = slot_tmask[cur_slot];
    assign cur_rs1   = slot_rs1[cur_slot];
    assign cur_rs2   = slot_rs2[cur_slot];

    assign cur_wid = warp_id_of(slot_wis[cur_slot], cur_slot);

    // a slot that is still being served must not change its instruction
    uuid_held_a: assert property (
        @(posedge clk) disable iff (reset)
        cur_valid && !batch_done |=> cur_valid && $stable(cur_uuid)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the lane dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f lane_dispatch.f --top-module lane_dispatch_tb \
    --Mdir "$BUILD_DIR" -o lane_dispatch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/lane_dispatch_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
exit 0
